// ==== tb.f ====
design/rx_link_pkg.sv
design/rx_frame_parser.sv
design/rx_word_packer.sv
design/rx_loss_monitor.sv
design/rx_dma_ctrl.sv
design/rx_link_top.sv
bench/rx_link_asserts.sv
bench/tb_rx_link.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the receive link testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_rx_link \
    -f tb.f -o sim_rx_link > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "Verilator build failed, see build.log"
    exit 1
fi

./obj_dir/sim_rx_link > sim.log 2>&1
run_status=$?

if grep -q "TEST FAIL" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi
if [ $run_status -ne 0 ] || ! grep -q "TEST PASS" sim.log; then
    echo "Simulation did not complete, see sim.log"
    exit 1
fi
echo "Simulation passed"
exit 0

// ==== bench/tb_rx_link.sv ====
/*
 * Receive link testbench
 * Random frames, loss symbols and DMA back-pressure against a queue model
 */
`timescale 1ns/1ps

module tb_rx_link
    import rx_link_pkg::*;
();

    localparam int N_FRAMES = 33;
    localparam int MAX_SYMS = 44;
    localparam int MAX_GAP  = 8;
    localparam int LIMIT    = 2 * (N_FRAMES * (MAX_SYMS + MAX_GAP) + 400 + 200 + 16);

    logic clk = 1'b0;
    logic i_reset, i_rkmsb, i_rklsb, i_wr_cmd_ack, i_rx_start, i_wr_finish;
    logic i_dma_wr_ready, i_link_loss_ena, i_sync_loss_ena;
    sym_t i_rxd;
    addr_t i_rx_base_addr;
    line_t i_frames_per_intr;
    logic o_wr_cmd_req, o_dma_wr_valid, o_frame_done, o_rx_interrupt;
    logic o_link_loss, o_sync_loss, o_loss_interrupt;
    wr_cmd_t o_wr_cmd;
    dword_t o_dma_wr_data;
    frame_info_t o_frame_info;

    integer seed = 32'h9968;
    int cycles = 0;
    dword_t exp_words[$];
    wr_cmd_t exp_cmds[$];
    frame_info_t exp_infos[$];
    addr_t exp_addr;
    int frame_cnt = 0;
    logic in_pl, exp_intr;
    // Loss model, index 0 is link loss and 1 is sync loss
    logic [1:0] exp_pulse, hold, hit, ena;
    int tmr[2];
    int link_pulses = 0;
    int sync_pulses = 0;

    rx_link_top dut_i (.*);

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > LIMIT) begin
            $display("Timeout, the run did not finish within %0d cycles", LIMIT);
            $display("TEST FAIL");
            $fatal(1);
        end
    end

    ////////////////////////////////
    // Compare tasks
    ////////////////////////////////
    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_dword(input string name, input dword_t exp, input dword_t act);
        if (exp !== act) fail_now($sformatf("FAILED %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_cmd(input string name, input wr_cmd_t exp, input wr_cmd_t act);
        if (exp !== act) fail_now($sformatf("FAILED %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_info(input string name, input frame_info_t exp,
                              input frame_info_t act);
        if (exp !== act) fail_now($sformatf("FAILED %s expected %h actual %h", name, exp, act));
    endtask

    task automatic check_pulse(input string name, input logic exp, input logic act);
        if (exp !== act) fail_now($sformatf("FAILED %s expected %b actual %b", name, exp, act));
    endtask

    ////////////////////////////////
    // Monitor and model, sampled mid-cycle
    ////////////////////////////////
    always @(negedge clk) begin
        if (i_reset) begin
            exp_pulse = '0;
            hold = '0;
            tmr[0] = 0;
            tmr[1] = 0;
        end else begin
            check_pulse("link_loss", exp_pulse[0], o_link_loss);
            check_pulse("sync_loss", exp_pulse[1], o_sync_loss);
            check_pulse("loss_interrupt", |exp_pulse, o_loss_interrupt);
            check_pulse("rx_interrupt", exp_intr, o_rx_interrupt);
            link_pulses += o_link_loss;
            sync_pulses += o_sync_loss;
            hit[0] = ({i_rkmsb, i_rklsb, i_rxd} == LINK_LOSS_WORD);
            hit[1] = (i_rkmsb | i_rklsb) & in_pl;
            ena = {i_sync_loss_ena, i_link_loss_ena};
            for (int g = 0; g < 2; g++) begin
                if (!ena[g]) begin
                    exp_pulse[g] = 1'b0;
                    hold[g] = 1'b0;
                    tmr[g] = 0;
                end else begin
                    exp_pulse[g] = hit[g] & ~hold[g];
                    if (hit[g] && !hold[g]) begin
                        hold[g] = 1'b1;
                        tmr[g] = 0;
                    end else if (hold[g]) begin
                        if (tmr[g] == LOSS_HOLDOFF - 1) hold[g] = 1'b0;
                        tmr[g]++;
                    end
                end
            end
            if (o_frame_done) begin
                if (exp_infos.size() == 0) fail_now("Frame done pulse without a sent frame");
                check_info("frame_info", exp_infos.pop_front(), o_frame_info);
            end
            if (o_dma_wr_valid) begin
                if (exp_words.size() == 0) fail_now("DMA data word that no frame produced");
                check_dword("dma_data", exp_words.pop_front(), o_dma_wr_data);
            end
            if (o_wr_cmd_req && i_wr_cmd_ack) begin
                if (exp_cmds.size() == 0) fail_now("DMA command that no frame produced");
                check_cmd("wr_cmd", exp_cmds.pop_front(), o_wr_cmd);
            end
        end
    end

    ////////////////////////////////
    // Stimulus
    ////////////////////////////////
    task automatic drive_sym(input ksym_t k, input logic pl, input logic fin);
        logic intr;
        intr = fin && (frame_cnt >= 3);
        if (intr) frame_cnt = 0;
        @(posedge clk);
        {i_rkmsb, i_rklsb, i_rxd} <= k;
        in_pl <= pl;
        i_wr_finish <= fin;
        exp_intr <= intr;
        i_dma_wr_ready <= $random(seed) & 1;
        i_wr_cmd_ack <= ($random(seed) & 3) != 0;
    endtask

    task automatic idle_gap(input int n, input logic allow_finish);
        for (int i = 0; i < n; i++) begin
            drive_sym('0, 1'b0, allow_finish && (($random(seed) & 3) == 0));
        end
    endtask

    task automatic send_frame(input logic corrupt, input logic inject_k);
        int nsym;
        int kpos;
        dlen_t len;
        sym_t typ;
        sym_t sum;
        sym_t data [32];
        frame_info_t info;
        dword_t w;
        wr_cmd_t cmd;
        nsym = 1 + (($random(seed) & 32'h7fff_ffff) % 32);
        len = dlen_t'(nsym * 2);
        info.file_end = $random(seed);
        info.channel = $random(seed);
        info.data_type = $random(seed);
        info.line_num = $random(seed);
        info.length = len;
        info.checksum_error = corrupt;
        typ = {info.file_end, info.channel, 1'b0, info.data_type, info.line_num[23:16]};
        sum = typ + info.line_num[15:0] + len;
        w = '0;
        for (int i = 0; i < nsym; i++) begin
            data[i] = $random(seed);
            sum += data[i];
            w[16 * (i % 4) +: 16] = data[i];
            if (i % 4 == 3 || i == nsym - 1) begin
                exp_words.push_back(w);
                w = '0;
            end
        end
        cmd.addr = exp_addr;
        cmd.bytes = (len + 16'd7) & 16'hFFF8;
        exp_addr += addr_t'(cmd.bytes);
        exp_cmds.push_back(cmd);
        exp_infos.push_back(info);
        kpos = inject_k ? (($random(seed) & 32'h7fff_ffff) % nsym) : -1;

        drive_sym(SYNC_WORD, 1'b0, 1'b0);
        drive_sym(START_WORD, 1'b0, 1'b0);
        drive_sym({2'b00, HEAD_HI}, 1'b0, 1'b0);
        drive_sym({2'b00, HEAD_LO}, 1'b0, 1'b0);
        drive_sym({2'b00, typ}, 1'b1, 1'b0);
        drive_sym({2'b00, info.line_num[15:0]}, 1'b1, 1'b0);
        drive_sym({2'b00, len}, 1'b1, 1'b0);
        for (int i = 0; i < nsym; i++) begin
            drive_sym({1'b0, i == kpos, data[i]}, 1'b1, 1'b0);
        end
        drive_sym({2'b00, corrupt ? sum + 16'd1 : sum}, 1'b1, 1'b0);
        drive_sym('0, 1'b0, 1'b0);
        frame_cnt++;
        drive_sym('0, 1'b0, 1'b0);
    endtask

    task automatic load_base(input addr_t base);
        i_rx_base_addr <= base;
        i_rx_start <= 1'b1;
        exp_addr = base;
        drive_sym('0, 1'b0, 1'b0);
        i_rx_start <= 1'b0;
    endtask

    initial begin
        i_reset = 1'b1;
        {i_rkmsb, i_rklsb, i_rxd} = '0;
        {i_wr_cmd_ack, i_rx_start, i_wr_finish, i_dma_wr_ready} = '0;
        {i_link_loss_ena, i_sync_loss_ena} = '0;
        i_rx_base_addr = '0;
        i_frames_per_intr = line_t'(3);
        in_pl = 1'b0;
        exp_intr = 1'b0;
        repeat (16) @(posedge clk);
        i_reset <= 1'b0;
        load_base(32'h1000_0000);

        for (int f = 0; f < 30; f++) begin
            if (f == 15) load_base(32'h2000_4000);
            idle_gap(1 + ($random(seed) & 7), 1'b1);
            send_frame((($random(seed) & 32'h7fff_ffff) % 5) == 0, 1'b0);
        end

        // Stray K code inside a payload, disabled then enabled
        idle_gap(4, 1'b0);
        send_frame(1'b0, 1'b1);
        i_sync_loss_ena <= 1'b1;
        idle_gap(4, 1'b0);
        send_frame(1'b0, 1'b1);
        // A short drop of the enable ends the hold-off, so this one reports again
        i_sync_loss_ena <= 1'b0;
        idle_gap(2, 1'b0);
        i_sync_loss_ena <= 1'b1;
        idle_gap(4, 1'b0);
        send_frame(1'b0, 1'b1);
        idle_gap(4, 1'b0);
        if (sync_pulses != 2) fail_now("Sync-loss pulse count is not two");

        // Link loss, a repeat inside the hold-off and one after it
        i_link_loss_ena <= 1'b1;
        idle_gap(2, 1'b0);
        drive_sym(LINK_LOSS_WORD, 1'b0, 1'b0);
        idle_gap(20, 1'b0);
        drive_sym(LINK_LOSS_WORD, 1'b0, 1'b0);
        idle_gap(LOSS_HOLDOFF + 40, 1'b0);
        drive_sym(LINK_LOSS_WORD, 1'b0, 1'b0);
        idle_gap(10, 1'b0);
        if (link_pulses != 2) fail_now("Link-loss pulse count is not two");

        while (exp_words.size() != 0 || exp_cmds.size() != 0) idle_gap(1, 1'b0);
        idle_gap(4, 1'b0);
        if (exp_infos.size() != 0) begin
            fail_now("Frames missing at the end of the run");
        end else begin
            $display("TEST PASS");
        end
        $finish;
    end

endmodule

// ==== bench/rx_link_asserts.sv ====
/*
 * Protocol assertions for the word buffer and the DMA command port
 */
`timescale 1ns/1ps

module rx_link_asserts
    import rx_link_pkg::*;
(
    input logic    clk,
    input logic    i_reset,
    input logic    wr_req,
    input logic    buf_full,
    input logic    wr_valid,
    input logic    wr_ready,
    input dword_t  wr_data,
    input logic    cmd_req,
    input logic    cmd_ack,
    input wr_cmd_t cmd
);

    a_no_full_write: assert property (@(posedge clk) disable iff (i_reset)
        !(wr_req && buf_full)) else $error("Write into a full word buffer");

    // A pending command holds its request and its fields until the ack
    a_req_hold: assert property (@(posedge clk) disable iff (i_reset)
        cmd_req && !cmd_ack |=> cmd_req && $stable(cmd))
        else $error("Command request dropped or changed before ack");

    a_valid_ready: assert property (@(posedge clk) disable iff (i_reset)
        wr_valid |-> wr_ready && !$isunknown(wr_data))
        else $error("Data valid without ready or with unknown data");

endmodule

bind rx_word_packer rx_link_asserts packer_chk_i (
    .clk(clk), .i_reset(i_reset), .wr_req(wr_req), .buf_full(buf_full),
    .wr_valid(o_dma_wr_valid), .wr_ready(i_dma_wr_ready), .wr_data(o_dma_wr_data),
    .cmd_req(1'b0), .cmd_ack(1'b0), .cmd('0)
);

bind rx_dma_ctrl rx_link_asserts dma_chk_i (
    .clk(clk), .i_reset(i_reset), .wr_req(1'b0), .buf_full(1'b0),
    .wr_valid(1'b0), .wr_ready(1'b0), .wr_data('0),
    .cmd_req(o_wr_cmd_req), .cmd_ack(i_wr_cmd_ack), .cmd(o_wr_cmd)
);

// ==== design/rx_link_top.sv ====
/*
 * Serial link receive top
 * Connects frame parser, word packer, loss monitor and DMA control
 */
`timescale 1ns/1ps

module rx_link_top
    import rx_link_pkg::*;
(
    input  logic        clk,
    input  logic        i_reset,
    input  logic        i_rkmsb,
    input  logic        i_rklsb,
    input  sym_t        i_rxd,
    input  logic        i_wr_cmd_ack,
    input  logic        i_rx_start,
    input  addr_t       i_rx_base_addr,
    input  line_t       i_frames_per_intr,
    input  logic        i_wr_finish,
    input  logic        i_dma_wr_ready,
    input  logic        i_link_loss_ena,
    input  logic        i_sync_loss_ena,
    output logic        o_wr_cmd_req,
    output wr_cmd_t     o_wr_cmd,
    output logic        o_dma_wr_valid,
    output dword_t      o_dma_wr_data,
    output logic        o_frame_done,
    output frame_info_t o_frame_info,
    output logic        o_rx_interrupt,
    output logic        o_link_loss,
    output logic        o_sync_loss,
    output logic        o_loss_interrupt
);

    logic  data_strobe;
    sym_t  data_sym;
    logic  frame_last;
    logic  length_strobe;
    dlen_t length;
    logic  frame_end;
    logic  in_payload;

    rx_frame_parser parser_i (
        .clk(clk), .i_reset(i_reset),
        .i_rkmsb(i_rkmsb), .i_rklsb(i_rklsb), .i_rxd(i_rxd),
        .o_data_strobe(data_strobe), .o_data_sym(data_sym),
        .o_frame_last(frame_last),
        .o_length_strobe(length_strobe), .o_length(length),
        .o_frame_end(frame_end),
        .o_frame_done(o_frame_done), .o_frame_info(o_frame_info),
        .o_in_payload(in_payload)
    );

    rx_word_packer packer_i (
        .clk(clk), .i_reset(i_reset),
        .i_data_strobe(data_strobe), .i_data_sym(data_sym),
        .i_frame_last(frame_last), .i_dma_wr_ready(i_dma_wr_ready),
        .o_dma_wr_valid(o_dma_wr_valid), .o_dma_wr_data(o_dma_wr_data)
    );

    rx_loss_monitor loss_i (
        .clk(clk), .i_reset(i_reset),
        .i_rkmsb(i_rkmsb), .i_rklsb(i_rklsb), .i_rxd(i_rxd),
        .i_in_payload(in_payload),
        .i_link_loss_ena(i_link_loss_ena), .i_sync_loss_ena(i_sync_loss_ena),
        .o_link_loss(o_link_loss), .o_sync_loss(o_sync_loss),
        .o_loss_interrupt(o_loss_interrupt)
    );

    rx_dma_ctrl dma_i (
        .clk(clk), .i_reset(i_reset),
        .i_length_strobe(length_strobe), .i_length(length),
        .i_frame_end(frame_end), .i_wr_cmd_ack(i_wr_cmd_ack),
        .i_rx_start(i_rx_start), .i_rx_base_addr(i_rx_base_addr),
        .i_frames_per_intr(i_frames_per_intr), .i_wr_finish(i_wr_finish),
        .o_wr_cmd_req(o_wr_cmd_req), .o_wr_cmd(o_wr_cmd),
        .o_rx_interrupt(o_rx_interrupt)
    );

endmodule

// ==== design/rx_dma_ctrl.sv ====
/*
 * DMA write control
 * Issues one write command per frame, steps the DDR address and
 * raises the frame-count interrupt on DMA completion
 */
`timescale 1ns/1ps

module rx_dma_ctrl
    import rx_link_pkg::*;
(
    input  logic    clk,
    input  logic    i_reset,
    input  logic    i_length_strobe,
    input  dlen_t   i_length,
    input  logic    i_frame_end,
    input  logic    i_wr_cmd_ack,
    input  logic    i_rx_start,
    input  addr_t   i_rx_base_addr,
    input  line_t   i_frames_per_intr,
    input  logic    i_wr_finish,
    output logic    o_wr_cmd_req,
    output wr_cmd_t o_wr_cmd,
    output logic    o_rx_interrupt
);

    // DDR writes go in whole 8-byte words
    function automatic dlen_t round_up8(input dlen_t len);
        round_up8 = {len[15:3] + 13'(|len[2:0]), 3'b000};
    endfunction

    logic    req_q;
    addr_t   addr_q;
    line_t   frame_cnt_q;
    wr_cmd_t cmd_now;
    wr_cmd_t cmd_q;

    assign cmd_now      = '{addr: addr_q, bytes: round_up8(i_length)};
    assign o_wr_cmd_req = i_length_strobe | req_q;
    assign o_wr_cmd     = i_length_strobe ? cmd_now : cmd_q;
    assign o_rx_interrupt = i_wr_finish && (frame_cnt_q != '0) &&
                            (frame_cnt_q >= i_frames_per_intr);

    always_ff @(posedge clk) begin
        if (i_length_strobe) cmd_q <= cmd_now;
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            req_q       <= 1'b0;
            addr_q      <= '0;
            frame_cnt_q <= '0;
        end else begin
            req_q <= (req_q | i_length_strobe) & ~i_wr_cmd_ack;

            if (i_rx_start) begin
                addr_q <= i_rx_base_addr;
            end else if (i_frame_end) begin
                addr_q <= addr_q + addr_t'(cmd_q.bytes);
            end

            // Count restarts at the interrupt, keeping a coincident frame end
            if (o_rx_interrupt) begin
                frame_cnt_q <= i_frame_end ? line_t'(1) : '0;
            end else if (i_frame_end) begin
                frame_cnt_q <= frame_cnt_q + line_t'(1);
            end
        end
    end

endmodule

// ==== design/rx_loss_monitor.sv ====
/*
 * Link and sync loss monitor
 * Reports link-loss symbols and stray K codes inside a frame, each
 * followed by a hold-off window that mutes repeat reports
 */
`timescale 1ns/1ps

module rx_loss_monitor
    import rx_link_pkg::*;
(
    input  logic clk,
    input  logic i_reset,
    input  logic i_rkmsb,
    input  logic i_rklsb,
    input  sym_t i_rxd,
    input  logic i_in_payload,
    input  logic i_link_loss_ena,
    input  logic i_sync_loss_ena,
    output logic o_link_loss,
    output logic o_sync_loss,
    output logic o_loss_interrupt
);

    // Detector 0 watches the link, detector 1 the frame sync
    logic [1:0] hit;
    logic [1:0] ena;
    wire  [1:0] pulse;

    assign hit[0] = ({i_rkmsb, i_rklsb, i_rxd} == LINK_LOSS_WORD);
    assign hit[1] = (i_rkmsb | i_rklsb) & i_in_payload;
    assign ena    = {i_sync_loss_ena, i_link_loss_ena};

    for (genvar g = 0; g < 2; g++) begin : g_det
        logic              pulse_q;
        logic              hold_q;
        logic [HOLD_W-1:0] timer_q;

        always_ff @(posedge clk) begin
            // A dropped enable also ends any hold-off in progress
            if (i_reset || !ena[g]) begin
                pulse_q <= 1'b0;
                hold_q  <= 1'b0;
                timer_q <= '0;
            end else begin
                pulse_q <= hit[g] & ~hold_q;
                if (hit[g] && !hold_q) begin
                    hold_q  <= 1'b1;
                    timer_q <= '0;
                end else if (hold_q) begin
                    if (timer_q == HOLD_W'(LOSS_HOLDOFF - 1)) hold_q <= 1'b0;
                    timer_q <= timer_q + 1'b1;
                end
            end
        end

        assign pulse[g] = pulse_q;
    end

    assign o_link_loss      = pulse[0];
    assign o_sync_loss      = pulse[1];
    assign o_loss_interrupt = |pulse;

endmodule

// ==== design/rx_word_packer.sv ====
/*
 * Payload word packer
 * Collects halfwords into 64-bit words, pads each frame with zeros to
 * a word boundary and queues the words for the DMA write port
 */
`timescale 1ns/1ps

module rx_word_packer
    import rx_link_pkg::*;
(
    input  logic   clk,
    input  logic   i_reset,
    input  logic   i_data_strobe,
    input  sym_t   i_data_sym,
    input  logic   i_frame_last,
    input  logic   i_dma_wr_ready,
    output logic   o_dma_wr_valid,
    output dword_t o_dma_wr_data
);

    localparam int LANE_W = $clog2(HALVES_PER_DWORD);

    logic [LANE_W-1:0]  lane_q;
    logic               pad_q;
    logic               take;
    logic               lane_last;
    sym_t               cur_half;
    dword_t             asm_q;
    dword_t             word_next;
    logic               wr_req;
    logic               buf_full;
    logic               buf_push;
    logic               buf_pop;
    dword_t             mem [BUF_DEPTH];
    logic [BUF_PTR_W-1:0] wr_ptr_q;
    logic [BUF_PTR_W-1:0] rd_ptr_q;
    logic [BUF_PTR_W:0]   count_q;

    ////////////////////////////////
    // Lane assembly
    ////////////////////////////////
    assign take      = i_data_strobe | pad_q;
    assign cur_half  = pad_q ? sym_t'(0) : i_data_sym;
    assign lane_last = (lane_q == LANE_W'(HALVES_PER_DWORD - 1));

    always_comb begin
        word_next = asm_q;
        word_next[lane_q * $bits(sym_t) +: $bits(sym_t)] = cur_half;
    end

    always_ff @(posedge clk) begin
        if (take) begin
            asm_q <= word_next;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            lane_q <= '0;
            pad_q  <= 1'b0;
        end else begin
            if (take) begin
                lane_q <= lane_q + 1'b1;
            end
            // Short final word, keep padding until the top lane
            if (i_data_strobe && i_frame_last && !lane_last) begin
                pad_q <= 1'b1;
            end else if (pad_q && lane_last) begin
                pad_q <= 1'b0;
            end
        end
    end

    ////////////////////////////////
    // Word buffer
    ////////////////////////////////
    assign wr_req   = take & lane_last;
    assign buf_full = (count_q == (BUF_PTR_W + 1)'(BUF_DEPTH));
    assign buf_push = wr_req & ~buf_full;
    assign buf_pop  = (count_q != '0) & i_dma_wr_ready;

    always_ff @(posedge clk) begin
        if (buf_push) begin
            mem[wr_ptr_q] <= word_next;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (buf_push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (buf_pop) rd_ptr_q <= rd_ptr_q + 1'b1;
            case ({buf_push, buf_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    assign o_dma_wr_valid = buf_pop;
    assign o_dma_wr_data  = mem[rd_ptr_q];

endmodule

// ==== design/rx_frame_parser.sv ====
/*
 * Receive frame parser
 * Hunts sync, start code and two-word head, captures the header fields,
 * streams payload halfwords out and checks the running checksum
 */
`timescale 1ns/1ps

module rx_frame_parser
    import rx_link_pkg::*;
(
    input  logic        clk,
    input  logic        i_reset,
    input  logic        i_rkmsb,
    input  logic        i_rklsb,
    input  sym_t        i_rxd,
    output logic        o_data_strobe,
    output sym_t        o_data_sym,
    output logic        o_frame_last,
    output logic        o_length_strobe,
    output dlen_t       o_length,
    output logic        o_frame_end,
    output logic        o_frame_done,
    output frame_info_t o_frame_info,
    output logic        o_in_payload
);

    rx_state_e   state_q;
    rx_state_e   state_d;
    ksym_t       ksym;
    sym_t        prev_sym;
    sym_t        sum_q;
    dlen_t       data_cnt;
    dlen_t       last_idx;
    frame_info_t info_q;

    assign ksym     = {i_rkmsb, i_rklsb, i_rxd};
    // Index of the final payload symbol, length is in bytes
    assign last_idx = dlen_t'(info_q.length[15:1]) - dlen_t'(1);

    ////////////////////////////////
    // Next state
    ////////////////////////////////
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE:   if (ksym == SYNC_WORD) state_d = ST_SYNC;
            ST_SYNC:   if (ksym == START_WORD) state_d = ST_HEAD;
            ST_HEAD: begin
                // Both head words, the older one from the delay register
                if (prev_sym == HEAD_HI && i_rxd == HEAD_LO) begin
                    state_d = ST_TYPE;
                end
            end
            ST_TYPE:   state_d = ST_LINE;
            ST_LINE:   state_d = ST_LENGTH;
            ST_LENGTH: state_d = ST_DATA;
            ST_DATA:   if (data_cnt == last_idx) state_d = ST_CHECK;
            ST_CHECK:  state_d = ST_END1;
            ST_END1:   state_d = ST_END2;
            ST_END2:   state_d = ST_IDLE;
            default:   state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state_q         <= ST_IDLE;
            info_q          <= '0;
            data_cnt        <= '0;
            o_data_strobe   <= 1'b0;
            o_frame_last    <= 1'b0;
            o_length_strobe <= 1'b0;
            o_frame_done    <= 1'b0;
        end else begin
            state_q         <= state_d;
            o_data_strobe   <= (state_q == ST_DATA);
            o_frame_last    <= (state_q == ST_DATA) && (data_cnt == last_idx);
            o_length_strobe <= (state_q == ST_LENGTH);
            o_frame_done    <= (state_q == ST_CHECK);

            case (state_q)
                ST_TYPE: begin
                    info_q.file_end        <= i_rxd[15];
                    info_q.channel         <= i_rxd[14:13];
                    info_q.data_type       <= i_rxd[11:8];
                    info_q.line_num[23:16] <= i_rxd[7:0];
                end
                ST_LINE:   info_q.line_num[15:0] <= i_rxd;
                ST_LENGTH: begin
                    info_q.length <= i_rxd;
                    data_cnt      <= '0;
                end
                ST_DATA:   data_cnt <= data_cnt + dlen_t'(1);
                ST_CHECK:  info_q.checksum_error <= (sum_q != i_rxd);
                default:   ;
            endcase
        end
    end

    // Symbol delay, payload register and checksum accumulator
    always_ff @(posedge clk) begin
        prev_sym   <= i_rxd;
        o_data_sym <= i_rxd;
        if (state_q == ST_TYPE) begin
            sum_q <= i_rxd;
        end else if (state_q inside {ST_LINE, ST_LENGTH, ST_DATA}) begin
            sum_q <= sum_q + i_rxd;
        end
    end

    assign o_length     = info_q.length;
    assign o_frame_end  = (state_q == ST_END1);
    assign o_frame_info = info_q;
    assign o_in_payload = state_q inside {ST_TYPE, ST_LINE, ST_LENGTH, ST_DATA, ST_CHECK};

endmodule

// ==== design/rx_link_pkg.sv ====
/*
 * Receive link shared definitions
 * Link control codes, frame layout constants, widths, types and the
 * parser state encoding used across the receive path
 */
package rx_link_pkg;

    ////////////////////////////////
    // Widths with a meaning
    ////////////////////////////////
    typedef logic [15:0] sym_t;
    // K-flagged symbol as {rkmsb, rklsb, data}
    typedef logic [17:0] ksym_t;
    typedef logic [63:0] dword_t;
    typedef logic [31:0] addr_t;
    typedef logic [15:0] dlen_t;
    typedef logic [23:0] line_t;

    // Link codes
    localparam ksym_t SYNC_WORD      = 18'h1_C5BC;  // K28.5 on low byte only
    localparam ksym_t START_WORD     = 18'h3_5CFB;  // K28.2, K27.7
    localparam sym_t  HEAD_HI        = 16'hEB90;
    localparam sym_t  HEAD_LO        = 16'hE116;
    localparam ksym_t LINK_LOSS_WORD = 18'h3_FFFF;

    localparam int LOSS_HOLDOFF     = 256;
    localparam int HOLD_W           = $clog2(LOSS_HOLDOFF + 1);
    localparam int BUF_DEPTH        = 16;
    localparam int BUF_PTR_W        = $clog2(BUF_DEPTH);
    localparam int HALVES_PER_DWORD = 4;

    ////////////////////////////////
    // Structures
    ////////////////////////////////
    typedef struct packed {
        logic       file_end;
        logic [1:0] channel;
        logic [3:0] data_type;
        line_t      line_num;
        dlen_t      length;
        logic       checksum_error;
    } frame_info_t;

    typedef struct packed {
        addr_t addr;
        dlen_t bytes;
    } wr_cmd_t;

    // Frame parser states, one symbol consumed per state
    typedef enum logic [3:0] {
        ST_IDLE, ST_SYNC, ST_HEAD, ST_TYPE, ST_LINE,
        ST_LENGTH, ST_DATA, ST_CHECK, ST_END1, ST_END2
    } rx_state_e;

endpackage
